// File: Makefile
# Verilator flow for the complex execution lane

VERILATOR ?= verilator
FILELIST  ?= complex_exec_lane.f
TB_TOP    ?= tb_complex_exec_lane
RTL_TOP   ?= complex_exec_lane
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: complex_exec_lane.f
hw/isa_pkg.sv
hw/exec_pkg.sv
hw/cx_ctrl.sv
hw/cx_operand_stage.sv
hw/complex_alu.sv
hw/cx_result_stage.sv
hw/complex_exec_lane.sv
test/tb_complex_exec_lane.sv

// File: hw/complex_alu.sv
// Complex arithmetic unit of the execution lane
// Signed and unsigned multiply and divide, syscall trap
// Purely combinational result and execution flags

`timescale 1ns/100ps

module complex_alu #(
  parameter int DATA_W = isa_pkg::DATA_W
) (
  input  isa_pkg::data_t        data1_i,
  input  isa_pkg::data_t        data2_i,
  input  isa_pkg::cx_op_e       op_i,
  output isa_pkg::data_t        result_o,
  output exec_pkg::exec_flags_t flags_o
);

  import isa_pkg::*;
  import exec_pkg::*;

  // Most negative signed operand, overflows when divided by -1
  localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};

  // Signed views of the operands
  logic signed [DATA_W-1:0] data1_s;
  logic signed [DATA_W-1:0] data2_s;

  // Double-width products
  logic signed [2*DATA_W-1:0] prod_s;
  logic [2*DATA_W-1:0] prod_u;

  // Divide corner cases
  logic div_zero;
  logic div_ovf;

  // Quotients and remainders
  logic signed [DATA_W-1:0] quot_s;
  logic signed [DATA_W-1:0] rem_s;
  logic [DATA_W-1:0] quot_u;
  logic [DATA_W-1:0] rem_u;

  assign data1_s = data1_i;
  assign data2_s = data2_i;

  // Operands cast to the product width keep their sign or zero extension
  assign prod_s = (2*DATA_W)'(data1_s) * (2*DATA_W)'(data2_s);
  assign prod_u = (2*DATA_W)'(data1_i) * (2*DATA_W)'(data2_i);

  assign div_zero = (data2_i == '0);
  assign div_ovf  = (data1_i == MOST_NEG) && (data2_i == '1);

  // Signed divide
  // Divide by zero gives all ones and keeps the dividend as remainder
  always_comb begin
    if (div_zero) begin
      quot_s = '1;
      rem_s  = data1_s;
    end else if (div_ovf) begin
      // Quotient wraps to the dividend, nothing left over
      quot_s = data1_s;
      rem_s  = '0;
    end else begin
      quot_s = data1_s / data2_s;
      rem_s  = data1_s % data2_s;
    end
  end

  // Unsigned divide, same zero divisor rule
  always_comb begin
    if (div_zero) begin
      quot_u = '1;
      rem_u  = data1_i;
    end else begin
      quot_u = data1_i / data2_i;
      rem_u  = data1_i % data2_i;
    end
  end

  // Flags shared by all multiply and divide ops
  function automatic exec_flags_t arith_flags(input logic lo);
    exec_flags_t f;
    f            = '0;
    f.dest_valid = 1'b1;
    f.writes_lo  = lo;
    f.executed   = 1'b1;
    return f;
  endfunction

  // Result select per opcode
  // Undefined opcodes leave result and flags at zero
  always_comb begin
    result_o = '0;
    flags_o  = '0;
    case (op_i)
      OP_MULT_L: begin
        result_o = prod_s[DATA_W-1:0];
        flags_o  = arith_flags(1'b1);
      end
      OP_MULT_H: begin
        result_o = prod_s[2*DATA_W-1:DATA_W];
        flags_o  = arith_flags(1'b0);
      end
      OP_MULTU_L: begin
        result_o = prod_u[DATA_W-1:0];
        flags_o  = arith_flags(1'b1);
      end
      OP_MULTU_H: begin
        result_o = prod_u[2*DATA_W-1:DATA_W];
        flags_o  = arith_flags(1'b0);
      end
      OP_DIV_L: begin
        result_o = quot_s;
        flags_o  = arith_flags(1'b1);
      end
      OP_DIV_H: begin
        result_o = rem_s;
        flags_o  = arith_flags(1'b0);
      end
      OP_DIVU_L: begin
        result_o = quot_u;
        flags_o  = arith_flags(1'b1);
      end
      OP_DIVU_H: begin
        result_o = rem_u;
        flags_o  = arith_flags(1'b0);
      end
      OP_SYSCALL: begin
        // Trap only, no register write
        flags_o.executed  = 1'b1;
        flags_o.exception = 1'b1;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// File: hw/complex_exec_lane.sv
// Complex execution lane, top level
// Operand stage, combinational complex unit and result stage
// Two cycles from issue to writeback, with result forwarding

`timescale 1ns/100ps

module complex_exec_lane #(
  parameter int DATA_W = isa_pkg::DATA_W,
  parameter int TAG_W  = isa_pkg::TAG_W
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                issue_valid_i,
  input  exec_pkg::cx_issue_t issue_i,
  input  logic                flush_i,
  output logic                wb_valid_o,
  output exec_pkg::cx_wb_t    wb_o
);

  import isa_pkg::*;
  import exec_pkg::*;

  // Stage load enables
  logic op_load;
  logic res_load;

  // Stage 1 payload after forwarding
  cx_issue_t s1_payload;

  // Unit outputs into the writeback register
  data_t       alu_result;
  exec_flags_t alu_flags;

  // Valids, loads and flush
  cx_ctrl u_ctrl (
    .clk           (clk),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .flush_i       (flush_i),
    .op_load_o     (op_load),
    .res_load_o    (res_load),
    .wb_valid_o    (wb_valid_o)
  );

  // Issue capture, the writeback packet is the forwarding source
  cx_operand_stage #(
    .TAG_W (TAG_W)
  ) u_operand_stage (
    .clk         (clk),
    .rst_i       (rst_i),
    .load_i      (op_load),
    .issue_i     (issue_i),
    .fwd_valid_i (wb_valid_o),
    .fwd_i       (wb_o),
    .payload_o   (s1_payload)
  );

  // Multiply, divide and trap
  complex_alu #(
    .DATA_W (DATA_W)
  ) u_complex_alu (
    .data1_i  (s1_payload.data1),
    .data2_i  (s1_payload.data2),
    .op_i     (s1_payload.op),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  // Writeback packet register
  cx_result_stage u_result_stage (
    .clk        (clk),
    .rst_i      (rst_i),
    .load_i     (res_load),
    .result_i   (alu_result),
    .flags_i    (alu_flags),
    .dest_tag_i (s1_payload.dest_tag),
    .wb_o       (wb_o)
  );

endmodule

// File: hw/cx_ctrl.sv
// Control for the complex execution lane
// Stage valid tracking, datapath load enables and flush handling

`timescale 1ns/100ps

module cx_ctrl (
  input  logic clk,
  input  logic rst_i,
  input  logic issue_valid_i,
  input  logic flush_i,
  output logic op_load_o,
  output logic res_load_o,
  output logic wb_valid_o
);

  // Valid of the instruction held in the operand register
  logic s1_valid;

  // Valid of the packet held in the writeback register
  logic wb_valid;

  // Operand register takes a new issue unless the lane is squashed
  assign op_load_o = issue_valid_i & ~flush_i;

  // Writeback register loads only when stage 1 holds a live instruction
  // Flush kills the instruction before it reaches writeback
  assign res_load_o = s1_valid & ~flush_i;

  // Valids move one stage per cycle
  // A flush edge clears both, since the loads are low then
  // A writeback already on the output in the flush cycle still shows
  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      s1_valid <= op_load_o;
      wb_valid <= res_load_o;
    end
  end

  // Writeback pulse, one cycle per instruction
  // Also qualifies the forwarding bus
  assign wb_valid_o = wb_valid;

endmodule

// File: hw/cx_operand_stage.sv
// Operand stage of the complex execution lane
// Captures the issue payload and forwards the leaving result
// onto source tags that match its destination

`timescale 1ns/100ps

module cx_operand_stage #(
  parameter int TAG_W = isa_pkg::TAG_W
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                load_i,
  input  exec_pkg::cx_issue_t issue_i,
  input  logic                fwd_valid_i,
  input  exec_pkg::cx_wb_t    fwd_i,
  output exec_pkg::cx_issue_t payload_o
);

  import exec_pkg::*;

  // Tag of the result currently leaving the lane
  logic [TAG_W-1:0] fwd_tag;

  // Source matches against the forwarding tag
  logic fwd_hit1;
  logic fwd_hit2;

  // Payload after forwarding, next register value
  cx_issue_t payload_d;

  assign fwd_tag = fwd_i.dest_tag;

  // Forwarding only counts while a writeback is showing
  assign fwd_hit1 = fwd_valid_i && (issue_i.src1_tag == fwd_tag);
  assign fwd_hit2 = fwd_valid_i && (issue_i.src2_tag == fwd_tag);

  always_comb begin
    payload_d = issue_i;
    // Issued data is stale when the producer writes back this cycle
    if (fwd_hit1) begin
      payload_d.data1 = fwd_i.result;
    end
    // Both sources may be replaced by the same result
    if (fwd_hit2) begin
      payload_d.data2 = fwd_i.result;
    end
  end

  // Payload register, holds its value while no instruction moves
  always_ff @(posedge clk) begin
    if (rst_i) begin
      payload_o <= '0;
    end else if (load_i) begin
      payload_o <= payload_d;
    end
  end

endmodule

// File: hw/cx_result_stage.sv
// Result stage of the complex execution lane
// Writeback register, also drives the forwarding bus

`timescale 1ns/100ps

module cx_result_stage (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  load_i,
  input  isa_pkg::data_t        result_i,
  input  exec_pkg::exec_flags_t flags_i,
  input  isa_pkg::tag_t         dest_tag_i,
  output exec_pkg::cx_wb_t      wb_o
);

  // Packet register
  // Holds the last packet while nothing moves, validity comes from control
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_o <= '0;
    end else if (load_i) begin
      // Tag travels with the result it names
      wb_o.dest_tag <= dest_tag_i;
      wb_o.result   <= result_i;
      wb_o.flags    <= flags_i;
    end
  end

endmodule

// File: hw/exec_pkg.sv
// Execution lane transport types
// Execution flag layout, issue payload and writeback packet

package exec_pkg;

  // Execution flags, msb first
  // Same bit order as the flag vector of the back end
  typedef struct packed {
    // Control transfer, never set by this lane
    logic ctrl;
    // Result goes to the destination register
    logic dest_valid;
    // Low half or quotient was produced
    logic writes_lo;
    // Instruction completed execution
    logic executed;
    // Trap raised, syscall only
    logic exception;
    // Branch mispredict, never set here
    logic mispredict;
  } exec_flags_t;

  // Issue payload handed over by the scheduler
  typedef struct packed {
    isa_pkg::cx_op_e op;
    // Source tags used for forwarding match
    isa_pkg::tag_t   src1_tag;
    isa_pkg::tag_t   src2_tag;
    // Operand values read at issue
    isa_pkg::data_t  data1;
    isa_pkg::data_t  data2;
    // Destination physical register
    isa_pkg::tag_t   dest_tag;
  } cx_issue_t;

  // Writeback packet, also the forwarding source
  typedef struct packed {
    isa_pkg::tag_t  dest_tag;
    isa_pkg::data_t result;
    exec_flags_t    flags;
  } cx_wb_t;

endpackage

// File: hw/isa_pkg.sv
// Instruction set definitions for the complex execution lane
// Operand and tag widths with their vector typedefs
// Opcode encoding of the multiply, divide and trap operations

package isa_pkg;

  // Operand and result width
  localparam int DATA_W = 32;

  // Physical register tag width
  localparam int TAG_W = 7;

  // Operand or result word
  typedef logic [DATA_W-1:0] data_t;

  // Physical register tag
  typedef logic [TAG_W-1:0] tag_t;

  // Complex lane opcodes
  // Suffix _L selects the low half or the quotient
  // Suffix _H selects the high half or the remainder
  typedef enum logic [3:0] {
    // Signed multiply
    OP_MULT_L  = 4'h0,
    OP_MULT_H  = 4'h1,
    // Unsigned multiply
    OP_MULTU_L = 4'h2,
    OP_MULTU_H = 4'h3,
    // Signed divide
    OP_DIV_L   = 4'h4,
    OP_DIV_H   = 4'h5,
    // Unsigned divide
    OP_DIVU_L  = 4'h6,
    OP_DIVU_H  = 4'h7,
    // System-call trap
    OP_SYSCALL = 4'h8
  } cx_op_e;

endpackage

// File: test/complex_exec_stim.txt
// One line per clock cycle, issue inputs first: valid op src1 src2 data1 data2 dest flush
// Then the writeback expected in the same cycle: valid tag result flags
// Flags 1c low or quotient, 14 high or remainder, 06 syscall trap
0 0 00 00 00000000 00000000 00 0 0 00 00000000 00
1 0 00 00 fffffffa 00000004 10 0 0 00 00000000 00
1 1 00 00 fffffffa 00000004 11 0 0 00 00000000 00
1 2 00 00 fffffffa 00000004 12 0 1 10 ffffffe8 1c
1 3 00 00 fffffffa 00000004 13 0 1 11 ffffffff 14
1 4 00 00 fffffff9 00000002 14 0 1 12 ffffffe8 1c
1 5 00 00 fffffff9 00000002 15 0 1 13 00000003 14
1 6 00 00 fffffff9 00000002 16 0 1 14 fffffffd 1c
1 7 00 00 fffffff9 00000002 17 0 1 15 ffffffff 14
1 4 00 00 00000064 fffffff9 18 0 1 16 7ffffffc 1c
1 5 00 00 00000064 fffffff9 19 0 1 17 00000001 14
1 6 00 00 00001234 00000000 1a 0 1 18 fffffff2 1c
1 5 00 00 87654321 00000000 1b 0 1 19 00000002 14
1 0 1a 05 00000000 00000003 20 0 1 1a ffffffff 1c
1 6 1b 1b 00000000 00000000 21 0 1 1b 87654321 14
1 4 02 20 0000001e 00000000 22 0 1 20 fffffffd 1c
1 8 00 00 11111111 22222222 1c 0 1 21 00000001 1c
1 3 33 44 80000000 00000004 23 0 1 22 fffffff6 1c
1 f 00 00 12345678 9abcdef0 24 0 1 1c 00000000 06
1 0 00 00 00000002 00000003 25 0 1 23 00000002 14
1 0 00 00 00000005 00000007 26 1 1 24 00000000 00
1 7 00 00 0000000a 00000003 27 0 0 00 00000000 00
0 0 00 00 00000000 00000000 00 0 0 00 00000000 00
0 0 00 00 00000000 00000000 00 0 1 27 00000001 14
0 0 00 00 00000000 00000000 00 0 0 00 00000000 00
0 0 00 00 00000000 00000000 00 0 0 00 00000000 00

// File: test/tb_complex_exec_lane.sv
// Testbench for the complex execution lane
// Replays the stim file cycle by cycle, then seeded random traffic
// Reference model of the lane rules, compare tasks and watchdog

`timescale 1ns/100ps

module tb_complex_exec_lane;

  import isa_pkg::*;
  import exec_pkg::*;

  localparam int    CLK_PERIOD  = 4;
  localparam int    N_STIM      = 26;
  localparam int    STIM_COLS   = 12;
  localparam int    N_RAND      = 40;
  localparam int    WATCHDOG_NS = (N_STIM + N_RAND + 20) * CLK_PERIOD;
  localparam string STIM_FILE   = "test/complex_exec_stim.txt";

  // DUT inputs, all start idle with reset high
  logic      clk           = 1'b0;
  logic      rst_i         = 1'b1;
  logic      issue_valid_i = 1'b0;
  cx_issue_t issue_i       = '0;
  logic      flush_i       = 1'b0;

  // DUT outputs
  logic   wb_valid_o;
  cx_wb_t wb_o;

  // Stim lines, STIM_COLS words each
  logic [31:0] stim_mem [0:N_STIM*STIM_COLS-1];

  // Expected writeback of the current stim line
  logic   exp_valid;
  cx_wb_t exp_wb;
  int     cur_line;
  logic   stim_active = 1'b0;
  logic   check_en    = 1'b0;

  // Reference model state
  logic      m_s1_valid;
  logic      m_wb_valid;
  cx_issue_t m_s1;
  cx_wb_t    m_wb;

  integer seed;
  int     cycle       = 0;
  int     n_checks    = 0;
  int     wb_count    = 0;
  int     dut_errors  = 0;
  int     stim_errors = 0;
  int     file_errors = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  complex_exec_lane #(
    .DATA_W (DATA_W),
    .TAG_W  (TAG_W)
  ) i_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .flush_i       (flush_i),
    .wb_valid_o    (wb_valid_o),
    .wb_o          (wb_o)
  );

  // Result per opcode, divide by zero gives all ones or the dividend
  function automatic data_t ref_result(input cx_op_e op, input data_t a, input data_t b);
    logic [2*DATA_W-1:0] prod_u;
    logic [2*DATA_W-1:0] prod_s;
    data_t mag_a;
    data_t mag_b;
    data_t quot;
    data_t rem;
    data_t res;
    prod_u = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    // Sign extended operands, low 2*DATA_W bits match the signed product
    prod_s = {{DATA_W{a[DATA_W-1]}}, a} * {{DATA_W{b[DATA_W-1]}}, b};
    // Signed divide on magnitudes
    mag_a = a[DATA_W-1] ? -a : a;
    mag_b = b[DATA_W-1] ? -b : b;
    if (b != '0) begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
    end else begin
      quot = '0;
      rem  = '0;
    end
    case (op)
      OP_MULT_L:  res = prod_s[DATA_W-1:0];
      OP_MULT_H:  res = prod_s[2*DATA_W-1:DATA_W];
      OP_MULTU_L: res = prod_u[DATA_W-1:0];
      OP_MULTU_H: res = prod_u[2*DATA_W-1:DATA_W];
      // Quotient sign from both operands
      OP_DIV_L:   res = (b == '0) ? '1 : ((a[DATA_W-1] ^ b[DATA_W-1]) ? -quot : quot);
      // Remainder sign follows the dividend
      OP_DIV_H:   res = (b == '0) ? a : (a[DATA_W-1] ? -rem : rem);
      OP_DIVU_L:  res = (b == '0) ? '1 : a / b;
      OP_DIVU_H:  res = (b == '0) ? a : a % b;
      // Syscall and undefined opcodes
      default:    res = '0;
    endcase
    return res;
  endfunction

  function automatic exec_flags_t ref_flags(input cx_op_e op);
    exec_flags_t f;
    f = '0;
    case (op)
      OP_MULT_L, OP_MULTU_L, OP_DIV_L, OP_DIVU_L: begin
        f.dest_valid = 1'b1;
        f.writes_lo  = 1'b1;
        f.executed   = 1'b1;
      end
      OP_MULT_H, OP_MULTU_H, OP_DIV_H, OP_DIVU_H: begin
        f.dest_valid = 1'b1;
        f.executed   = 1'b1;
      end
      OP_SYSCALL: begin
        f.executed  = 1'b1;
        f.exception = 1'b1;
      end
      default: f = '0;
    endcase
    return f;
  endfunction

  // Leaving result replaces any source with a matching tag
  function automatic cx_issue_t forward_operands(input cx_issue_t p, input logic fwd_valid,
                                                 input cx_wb_t fwd);
    cx_issue_t q;
    q = p;
    if (fwd_valid && (p.src1_tag == fwd.dest_tag)) begin
      q.data1 = fwd.result;
    end
    if (fwd_valid && (p.src2_tag == fwd.dest_tag)) begin
      q.data2 = fwd.result;
    end
    return q;
  endfunction

  // Two stage model, flush squashes both stages
  always @(posedge clk) begin
    if (rst_i) begin
      m_s1_valid <= 1'b0;
      m_wb_valid <= 1'b0;
    end else begin
      m_s1_valid <= issue_valid_i && !flush_i;
      m_wb_valid <= m_s1_valid && !flush_i;
      if (issue_valid_i && !flush_i) begin
        m_s1 <= forward_operands(issue_i, m_wb_valid, m_wb);
      end
      if (m_s1_valid && !flush_i) begin
        m_wb.dest_tag <= m_s1.dest_tag;
        m_wb.result   <= ref_result(m_s1.op, m_s1.data1, m_s1.data2);
        m_wb.flags    <= ref_flags(m_s1.op);
      end
    end
  end

  task automatic check_valid(input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      dut_errors++;
      $display("mismatch wb_valid_o in cycle %0d: got %h expected %h", cycle, got, exp);
    end
  endtask

  task automatic check_wb(input cx_wb_t got, input cx_wb_t exp);
    n_checks++;
    if (got !== exp) begin
      dut_errors++;
      $display("mismatch wb_o in cycle %0d: got tag %h result %h flags %h",
               cycle, got.dest_tag, got.result, got.flags);
      $display("  expected tag %h result %h flags %h", exp.dest_tag, exp.result, exp.flags);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (check_en) begin
      if (wb_valid_o === 1'b1) begin
        wb_count++;
      end
      if (stim_active) begin
        check_valid(wb_valid_o, exp_valid);
        if (exp_valid) begin
          check_wb(wb_o, exp_wb);
        end
        // Stim expectations must agree with the lane rules
        if ((exp_valid !== m_wb_valid) || (exp_valid && (exp_wb !== m_wb))) begin
          stim_errors++;
          $display("Stim line %0d has an expected writeback the reference model disagrees with",
                   cur_line);
        end
      end else begin
        check_valid(wb_valid_o, m_wb_valid);
        if (m_wb_valid) begin
          check_wb(wb_o, m_wb);
        end
      end
    end
  end

  task automatic apply_stim_line(input int line);
    int base;
    base = line * STIM_COLS;
    issue_valid_i     <= stim_mem[base][0];
    issue_i.op        <= cx_op_e'(stim_mem[base+1][3:0]);
    issue_i.src1_tag  <= stim_mem[base+2][TAG_W-1:0];
    issue_i.src2_tag  <= stim_mem[base+3][TAG_W-1:0];
    issue_i.data1     <= stim_mem[base+4];
    issue_i.data2     <= stim_mem[base+5];
    issue_i.dest_tag  <= stim_mem[base+6][TAG_W-1:0];
    flush_i           <= stim_mem[base+7][0];
    // Expected output during this same cycle
    exp_valid       = stim_mem[base+8][0];
    exp_wb.dest_tag = stim_mem[base+9][TAG_W-1:0];
    exp_wb.result   = stim_mem[base+10];
    exp_wb.flags    = exec_flags_t'(stim_mem[base+11][5:0]);
    cur_line        = line;
    stim_active     = 1'b1;
  endtask

  // Small tag range so forwarding hits are frequent
  task automatic apply_random_cycle();
    logic [31:0] r;
    logic [3:0]  op_bits;
    cx_issue_t   pkt;
    r       = $random(seed);
    op_bits = r[7:4];
    if (op_bits > 4'h9) begin
      op_bits = op_bits - 4'h8;
    end
    pkt.op       = cx_op_e'(op_bits);
    pkt.src1_tag = {{(TAG_W-2){1'b0}}, r[9:8]};
    pkt.src2_tag = {{(TAG_W-2){1'b0}}, r[11:10]};
    pkt.dest_tag = {{(TAG_W-2){1'b0}}, r[13:12]};
    pkt.data1    = $random(seed);
    pkt.data2    = $random(seed);
    // Zero divisor now and then
    if (r[15:14] == 2'b00) begin
      pkt.data2 = '0;
    end
    issue_valid_i <= (r[1:0] != 2'b00);
    issue_i       <= pkt;
    flush_i       <= (r[23:21] == 3'b000);
    stim_active    = 1'b0;
  endtask

  task automatic apply_idle();
    issue_valid_i <= 1'b0;
    flush_i       <= 1'b0;
    stim_active    = 1'b0;
  endtask

  initial begin
    seed = 94503;
    // Sentinel in the last flags word survives only a short stim file
    stim_mem[N_STIM*STIM_COLS-1] = '1;
    $readmemh(STIM_FILE, stim_mem);
    if (stim_mem[N_STIM*STIM_COLS-1][31:6] !== '0) begin
      file_errors++;
      $display("The stim file holds fewer lines than the testbench replays");
    end
    // Reset held for three edges, checked from the first one
    @(posedge clk);
    check_en = 1'b1;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    for (int line = 0; line < N_STIM; line++) begin
      apply_stim_line(line);
      @(posedge clk);
    end
    for (int n = 0; n < N_RAND; n++) begin
      apply_random_cycle();
      @(posedge clk);
    end
    // Drain until nothing is in flight
    apply_idle();
    do begin
      @(negedge clk);
    end while (m_s1_valid || m_wb_valid);
    @(posedge clk);
    $display("Checks %0d, writebacks %0d, DUT errors %0d, stim errors %0d, file errors %0d",
             n_checks, wb_count, dut_errors, stim_errors, file_errors);
    if ((dut_errors == 0) && (stim_errors == 0) && (file_errors == 0)) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule
